// File: sources.f
verilog/port_dma_pkg.sv
verilog/free_ptr_list.sv
verilog/cell_writer.sv
verilog/port_sgdma.sv
test/port_sgdma_properties.sv
test/port_sgdma_tb.sv

// File: run.sh
#!/bin/sh
# build and run the port_sgdma testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f sources.f \
    --top-module port_sgdma_tb \
    -Mdir obj_dir \
    -o port_sgdma_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/port_sgdma_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// File: test/port_sgdma_tb.sv
`timescale 1ns/100ps

module port_sgdma_tb;

    localparam port_dma_pkg::port_t PORT = 4'd3;
    localparam int NPKT    = 12;
    localparam int TIMEOUT = 6000;

    ////////////////////
    // packet table
    ////////////////////

    // payload length in bytes, priority, destination port
    localparam int PKT_LEN  [NPKT] = '{0, 1, 16, 17, 100, 255, 400, 640, 33, 1000, 15, 512};
    localparam int PKT_PRIO [NPKT] = '{0, 7, 1, 2, 3, 4, 5, 6, 7, 0, 1, 2};
    localparam int PKT_DEST [NPKT] = '{1, 2, 15, 0, 4, 9, 3, 8, 12, 5, 6, 11};

    logic                i_clk;
    logic                i_rst_n;
    logic                i_locked;
    port_dma_pkg::data_t i_dat;
    logic                i_empty;
    logic                i_cb_full;
    logic                i_mmu_wr_ready;
    logic                i_mmu_malloc_done;
    logic                i_fp_wr_en;
    port_dma_pkg::addr_t i_fp_wr_dat;
    logic                o_rd_en;
    port_dma_pkg::desc_t o_cb_din;
    logic                o_cb_wr_en;
    logic                o_mmu_wr_req;
    port_dma_pkg::port_t o_sram_sel;
    logic                o_mmu_wr_en;
    port_dma_pkg::addr_t o_mmu_wr_addr;
    port_dma_pkg::data_t o_mmu_wr_dat;
    logic                o_mmu_wr_done;
    logic                o_aply_req;
    port_dma_pkg::cnt_t  o_length;

    // input FIFO model with the head at index 0
    port_dma_pkg::data_t fifo_q [$];
    // expected traffic
    port_dma_pkg::addr_t exp_addr_q [$];
    port_dma_pkg::data_t exp_dat_q [$];
    port_dma_pkg::desc_t exp_desc_q [$];
    port_dma_pkg::cnt_t  exp_cells_q [$];
    port_dma_pkg::cnt_t  exp_len_q [$];

    integer seed = 32'h76fe_718e;

    port_sgdma #(
        .P_PORT (PORT)
    ) uut (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_locked          (i_locked),
        .i_dat             (i_dat),
        .i_empty           (i_empty),
        .o_rd_en           (o_rd_en),
        .o_cb_din          (o_cb_din),
        .o_cb_wr_en        (o_cb_wr_en),
        .i_cb_full         (i_cb_full),
        .o_mmu_wr_req      (o_mmu_wr_req),
        .o_sram_sel        (o_sram_sel),
        .o_mmu_wr_en       (o_mmu_wr_en),
        .o_mmu_wr_addr     (o_mmu_wr_addr),
        .o_mmu_wr_dat      (o_mmu_wr_dat),
        .o_mmu_wr_done     (o_mmu_wr_done),
        .i_mmu_wr_ready    (i_mmu_wr_ready),
        .i_mmu_malloc_done (i_mmu_malloc_done),
        .i_fp_wr_en        (i_fp_wr_en),
        .i_fp_wr_dat       (i_fp_wr_dat),
        .o_aply_req        (o_aply_req),
        .o_length          (o_length)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input port_dma_pkg::addr_t got,
                              input port_dma_pkg::addr_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input port_dma_pkg::data_t got,
                              input port_dma_pkg::data_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_desc(input string name, input port_dma_pkg::desc_t got,
                              input port_dma_pkg::desc_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_cnt(input string name, input port_dma_pkg::cnt_t got,
                             input port_dma_pkg::cnt_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_port(input string name, input port_dma_pkg::port_t got,
                              input port_dma_pkg::port_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Error %s got %h expected %h", name, got, exp));
        end
    endtask

    // header cell plus payload cells rounded up
    function automatic port_dma_pkg::cnt_t cells_for(input int len);
        return port_dma_pkg::cnt_t'((len + 15) / 16 + 1);
    endfunction

    // fill addresses 0..127 then refilled ones from 128 upward
    function automatic port_dma_pkg::addr_t addr_for(input int idx);
        if (idx < 128) begin
            return {PORT, 5'd0, 7'(idx)};
        end
        return {PORT, 12'(idx)};
    endfunction

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        int cell_idx;
        int ncell;
        int rnd;
        int cyc;
        int locked_cyc;
        int done_cnt;
        int malloc_cnt;
        int written;
        int ret_idx;
        int ret_backlog;
        int done_delay;
        int cb_hold;
        logic pop_pending;
        logic aply_prev;
        logic req_open;
        port_dma_pkg::data_t hdr;

        i_rst_n           = 1'b0;
        i_locked          = 1'b0;
        i_dat             = '0;
        i_empty           = 1'b1;
        i_cb_full         = 1'b0;
        i_mmu_wr_ready    = 1'b0;
        i_mmu_malloc_done = 1'b0;
        i_fp_wr_en        = 1'b0;
        i_fp_wr_dat       = '0;
        cell_idx    = 0;
        done_cnt    = 0;
        malloc_cnt  = 0;
        written     = 0;
        ret_idx     = 128;
        ret_backlog = 0;
        done_delay  = 0;
        cb_hold     = 0;
        locked_cyc  = 0;
        pop_pending = 1'b0;
        aply_prev   = 1'b0;
        req_open    = 1'b0;

        // expand table into FIFO words and expected traffic
        for (int p = 0; p < NPKT; p++) begin
            ncell = int'(cells_for(PKT_LEN[p]));
            hdr = {10'd0, PORT, 11'(PKT_LEN[p]), 3'(PKT_PRIO[p]), 4'(PKT_DEST[p])};
            exp_desc_q.push_back({addr_for(cell_idx), cells_for(PKT_LEN[p]), hdr[6:0]});
            exp_cells_q.push_back(cells_for(PKT_LEN[p]));
            exp_len_q.push_back(cells_for(PKT_LEN[p]));
            for (int c = 0; c < ncell; c++) begin
                if (c != 0) begin
                    hdr = $random(seed);
                end
                fifo_q.push_back(hdr);
                exp_dat_q.push_back(hdr);
                exp_addr_q.push_back(addr_for(cell_idx));
                cell_idx++;
            end
        end

        repeat (8) @(negedge i_clk);
        i_rst_n = 1'b1;
        i_dat   = fifo_q[0];
        i_empty = 1'b0;

        // nothing may move while locked is low
        cyc = 0;
        while (cyc < 20) begin
            @(negedge i_clk);
            if (o_rd_en || o_mmu_wr_req || o_mmu_wr_en || o_cb_wr_en) begin
                fail_now("activity seen while i_locked was low");
            end
            cyc++;
        end
        check_port("o_sram_sel", o_sram_sel, PORT);
        i_locked = 1'b1;

        cyc = 0;
        while (done_cnt < NPKT || malloc_cnt < NPKT || ret_backlog > 0) begin
            @(negedge i_clk);
            cyc++;
            locked_cyc++;
            if (cyc > TIMEOUT) begin
                fail_now("timeout waiting for all packets to finish");
            end

            //////////////////// monitor
            if (o_mmu_wr_req) begin
                // start needs lock and crossbar space in the cycle before
                if (!i_locked || i_cb_full) begin
                    fail_now("MMU write request started while locked low or crossbar full");
                end
                if (req_open) begin
                    fail_now("second MMU write request before the header write");
                end
                req_open = 1'b1;
            end
            if (o_mmu_wr_en) begin
                if (exp_addr_q.size() == 0) begin
                    fail_now("MMU write with no cell left to expect");
                end
                check_addr("o_mmu_wr_addr", o_mmu_wr_addr, exp_addr_q.pop_front());
                check_data("o_mmu_wr_dat", o_mmu_wr_dat, exp_dat_q.pop_front());
                written++;
            end
            if (o_cb_wr_en) begin
                if (exp_desc_q.size() == 0) begin
                    fail_now("descriptor posted with none left to expect");
                end
                if (!req_open) begin
                    fail_now("descriptor posted without an MMU write request");
                end
                req_open = 1'b0;
                check_desc("o_cb_din", o_cb_din, exp_desc_q.pop_front());
            end
            if (o_mmu_wr_done) begin
                if (exp_cells_q.size() == 0) begin
                    fail_now("done pulse with no packet outstanding");
                end
                check_cnt("cells written", 7'(written), exp_cells_q.pop_front());
                written = 0;
                done_cnt++;
            end
            // new refill request
            if (o_aply_req && !aply_prev) begin
                if (exp_len_q.size() == 0) begin
                    fail_now("refill request with no packet outstanding");
                end
                check_cnt("o_length", o_length, exp_len_q.pop_front());
                ret_backlog = ret_backlog + int'(o_length);
                done_delay = 2;
            end
            aply_prev = o_aply_req;

            //////////////////// FIFO model
            if (pop_pending) begin
                void'(fifo_q.pop_front());
            end
            rnd = $random(seed);
            i_dat   = (fifo_q.size() > 0) ? fifo_q[0] : '0;
            i_empty = (fifo_q.size() == 0) || (rnd[1:0] == 2'b00);

            // crossbar full in stretches
            if (cb_hold > 0) begin
                cb_hold--;
            end else if (rnd[7:4] == 4'd0) begin
                cb_hold = 12;
            end
            i_cb_full = (cb_hold > 0);

            //////////////////// MMU model
            i_mmu_wr_ready    = rnd[2];
            i_mmu_malloc_done = 1'b0;
            if (done_delay > 0) begin
                done_delay--;
                if (done_delay == 0) begin
                    i_mmu_malloc_done = 1'b1;
                    malloc_cnt++;
                end
            end
            // returns only after the power-up fill is surely over
            i_fp_wr_en = 1'b0;
            if (locked_cyc > 140 && ret_backlog > 0 && rnd[3]) begin
                i_fp_wr_en  = 1'b1;
                i_fp_wr_dat = addr_for(ret_idx);
                ret_idx++;
                ret_backlog--;
            end

            // clock lock drops for a while once the fill is over
            i_locked = !(locked_cyc >= 200 && locked_cyc < 240);

            // read enable settles before the next rising edge
            #1;
            pop_pending = o_rd_en;
        end

        if (exp_addr_q.size() != 0 || exp_desc_q.size() != 0 || fifo_q.size() != 0) begin
            fail_now("cells or descriptors missing at end of run");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: test/port_sgdma_properties.sv
`timescale 1ns/100ps

module port_sgdma_properties (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_empty,
    input logic o_rd_en,
    input logic o_mmu_wr_req,
    input logic o_aply_req,
    input logic i_mmu_malloc_done,
    input logic o_cb_wr_en,
    input logic o_mmu_wr_en
);

    ////////////////////
    // input FIFO
    ////////////////////

    // never pop an empty FIFO
    a_no_pop_empty : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_rd_en && i_empty))
        else $error("o_rd_en high while i_empty high");

    ////////////////////
    // MMU handshakes
    ////////////////////

    // request is one cycle wide
    a_req_pulse : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_mmu_wr_req |=> !o_mmu_wr_req)
        else $error("o_mmu_wr_req longer than one cycle");

    // refill held until malloc done
    a_aply_hold : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_aply_req && !i_mmu_malloc_done) |=> o_aply_req)
        else $error("o_aply_req dropped before i_mmu_malloc_done");

    // descriptor rides with header write
    a_desc_with_write : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_cb_wr_en |-> o_mmu_wr_en)
        else $error("o_cb_wr_en without o_mmu_wr_en");

endmodule

bind port_sgdma port_sgdma_properties u_props (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_empty           (i_empty),
    .o_rd_en           (o_rd_en),
    .o_mmu_wr_req      (o_mmu_wr_req),
    .o_aply_req        (o_aply_req),
    .i_mmu_malloc_done (i_mmu_malloc_done),
    .o_cb_wr_en        (o_cb_wr_en),
    .o_mmu_wr_en       (o_mmu_wr_en)
);

// File: verilog/port_sgdma.sv
`timescale 1ns/100ps

module port_sgdma #(
    parameter port_dma_pkg::port_t P_PORT = '0
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_locked,
    // input FIFO
    input  port_dma_pkg::data_t i_dat,
    input  logic                i_empty,
    output logic                o_rd_en,
    // crossbar
    output port_dma_pkg::desc_t o_cb_din,
    output logic                o_cb_wr_en,
    input  logic                i_cb_full,
    // MMU write side
    output logic                o_mmu_wr_req,
    output port_dma_pkg::port_t o_sram_sel,
    output logic                o_mmu_wr_en,
    output port_dma_pkg::addr_t o_mmu_wr_addr,
    output port_dma_pkg::data_t o_mmu_wr_dat,
    output logic                o_mmu_wr_done,
    input  logic                i_mmu_wr_ready,
    // MMU refill side
    input  logic                i_mmu_malloc_done,
    input  logic                i_fp_wr_en,
    input  port_dma_pkg::addr_t i_fp_wr_dat,
    output logic                o_aply_req,
    output port_dma_pkg::cnt_t  o_length
);

    // free list to writer
    port_dma_pkg::addr_t fp_addr;
    logic                fp_empty;
    logic                fp_pop;
    // writer to refill
    logic                pkt_start;
    port_dma_pkg::cnt_t  pkt_cells;

    // memory region is this port
    assign o_sram_sel = P_PORT;

    ////////////////////
    // free address supply
    ////////////////////

    free_ptr_list #(
        .P_PORT (P_PORT)
    ) u_fp (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_locked          (i_locked),
        .i_pop             (fp_pop),
        .i_fp_wr_en        (i_fp_wr_en),
        .i_fp_wr_dat       (i_fp_wr_dat),
        .i_pkt_start       (pkt_start),
        .i_pkt_cells       (pkt_cells),
        .i_mmu_malloc_done (i_mmu_malloc_done),
        .o_addr            (fp_addr),
        .o_empty           (fp_empty),
        .o_aply_req        (o_aply_req),
        .o_length          (o_length)
    );

    ////////////////////
    // cell writer
    ////////////////////

    cell_writer u_wr (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_locked       (i_locked),
        .i_empty        (i_empty),
        .i_dat          (i_dat),
        .i_fp_addr      (fp_addr),
        .i_fp_empty     (fp_empty),
        .i_cb_full      (i_cb_full),
        .i_mmu_wr_ready (i_mmu_wr_ready),
        .o_rd_en        (o_rd_en),
        .o_fp_pop       (fp_pop),
        .o_mmu_wr_req   (o_mmu_wr_req),
        .o_mmu_wr_en    (o_mmu_wr_en),
        .o_mmu_wr_addr  (o_mmu_wr_addr),
        .o_mmu_wr_dat   (o_mmu_wr_dat),
        .o_mmu_wr_done  (o_mmu_wr_done),
        .o_cb_din       (o_cb_din),
        .o_cb_wr_en     (o_cb_wr_en),
        .o_pkt_start    (pkt_start),
        .o_pkt_cells    (pkt_cells)
    );

endmodule

// File: verilog/cell_writer.sv
`timescale 1ns/100ps

module cell_writer (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_locked,
    input  logic                i_empty,
    input  port_dma_pkg::data_t i_dat,
    input  port_dma_pkg::addr_t i_fp_addr,
    input  logic                i_fp_empty,
    input  logic                i_cb_full,
    input  logic                i_mmu_wr_ready,
    output logic                o_rd_en,
    output logic                o_fp_pop,
    output logic                o_mmu_wr_req,
    output logic                o_mmu_wr_en,
    output port_dma_pkg::addr_t o_mmu_wr_addr,
    output port_dma_pkg::data_t o_mmu_wr_dat,
    output logic                o_mmu_wr_done,
    output port_dma_pkg::desc_t o_cb_din,
    output logic                o_cb_wr_en,
    output logic                o_pkt_start,
    output port_dma_pkg::cnt_t  o_pkt_cells
);

    localparam int LEN_W = port_dma_pkg::HDR_LEN_MSB - port_dma_pkg::HDR_LEN_LSB + 1;
    localparam int FRAC_W = port_dma_pkg::CELL_BYTES_LOG2;

    port_dma_pkg::writer_state_t state;
    // body cells still to write
    port_dma_pkg::cnt_t          body_left;
    logic [LEN_W-1:0]            hdr_len;
    logic [LEN_W-1:0]            len_cells;
    port_dma_pkg::cnt_t          hdr_cells;
    logic                        src_ready;
    logic                        start_ok;
    logic                        hdr_pop;
    logic                        cell_pop;

    ////////////////////
    // header parse
    ////////////////////

    assign hdr_len = i_dat[port_dma_pkg::HDR_LEN_MSB:port_dma_pkg::HDR_LEN_LSB];

    // payload bytes to cells, rounded up
    assign len_cells = (hdr_len >> FRAC_W)
                     + LEN_W'(|hdr_len[FRAC_W-1:0]);

    // plus the header cell
    assign hdr_cells = port_dma_pkg::cnt_t'(len_cells + LEN_W'(1));

    ////////////////////
    // pops and strobes
    ////////////////////

    // a cell moves only with a word and a free address both present
    assign src_ready = !i_empty && !i_fp_empty;
    // crossbar space and clock lock checked at packet start only
    assign start_ok  = i_locked && src_ready && !i_cb_full;

    assign hdr_pop  = (state == port_dma_pkg::WR_HEADER) && src_ready;
    assign cell_pop = hdr_pop || ((state == port_dma_pkg::WR_BODY) && src_ready);

    // input word and free address always leave together
    assign o_rd_en  = cell_pop;
    assign o_fp_pop = cell_pop;

    assign o_mmu_wr_req = (state == port_dma_pkg::WR_REQUEST);

    // refill side sees the count while the header is consumed
    assign o_pkt_start = hdr_pop;
    assign o_pkt_cells = hdr_cells;

    ////////////////////
    // packet FSM
    ////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state         <= port_dma_pkg::WR_IDLE;
            body_left     <= '0;
            o_mmu_wr_en   <= 1'b0;
            o_cb_wr_en    <= 1'b0;
            o_mmu_wr_done <= 1'b0;
        end else begin
            // write follows its pop by one cycle
            o_mmu_wr_en   <= cell_pop;
            // descriptor goes out with the header write
            o_cb_wr_en    <= hdr_pop;
            // done lands one cycle after the last write
            o_mmu_wr_done <= (state == port_dma_pkg::WR_DONE);
            case (state)
                port_dma_pkg::WR_IDLE: begin
                    if (start_ok) begin
                        state <= port_dma_pkg::WR_REQUEST;
                    end
                end
                port_dma_pkg::WR_REQUEST: begin
                    // one-cycle request to the MMU
                    state <= port_dma_pkg::WR_WAIT_READY;
                end
                port_dma_pkg::WR_WAIT_READY: begin
                    if (i_mmu_wr_ready) begin
                        state <= port_dma_pkg::WR_HEADER;
                    end
                end
                port_dma_pkg::WR_HEADER: begin
                    if (hdr_pop) begin
                        body_left <= hdr_cells - 1'b1;
                        // header-only packet skips the body
                        if (hdr_cells == port_dma_pkg::cnt_t'(1)) begin
                            state <= port_dma_pkg::WR_DONE;
                        end else begin
                            state <= port_dma_pkg::WR_BODY;
                        end
                    end
                end
                port_dma_pkg::WR_BODY: begin
                    // holds without a pop when either source runs dry
                    if (cell_pop) begin
                        body_left <= body_left - 1'b1;
                        if (body_left == port_dma_pkg::cnt_t'(1)) begin
                            state <= port_dma_pkg::WR_DONE;
                        end
                    end
                end
                port_dma_pkg::WR_DONE: begin
                    state <= port_dma_pkg::WR_IDLE;
                end
                default: begin
                    state <= port_dma_pkg::WR_IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // write and descriptor data
    ////////////////////

    always_ff @(posedge i_clk) begin
        if (cell_pop) begin
            o_mmu_wr_addr <= i_fp_addr;
            o_mmu_wr_dat  <= i_dat;
        end
        // first address, count, priority and dest port
        if (hdr_pop) begin
            o_cb_din <= {i_fp_addr, hdr_cells, i_dat[port_dma_pkg::HDR_ROUTE_W-1:0]};
        end
    end

endmodule

// File: verilog/free_ptr_list.sv
`timescale 1ns/100ps

module free_ptr_list #(
    parameter port_dma_pkg::port_t P_PORT = '0
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_locked,
    input  logic                i_pop,
    input  logic                i_fp_wr_en,
    input  port_dma_pkg::addr_t i_fp_wr_dat,
    input  logic                i_pkt_start,
    input  port_dma_pkg::cnt_t  i_pkt_cells,
    input  logic                i_mmu_malloc_done,
    output port_dma_pkg::addr_t o_addr,
    output logic                o_empty,
    output logic                o_aply_req,
    output port_dma_pkg::cnt_t  o_length
);

    localparam int PTR_W  = $clog2(port_dma_pkg::FP_DEPTH);
    localparam int IDX_W  = $clog2(port_dma_pkg::FP_INIT_ENTRIES);
    localparam int FILL_W = IDX_W + 1;
    localparam int PAD_W  = port_dma_pkg::ADDR_W - port_dma_pkg::PORT_W - IDX_W;

    port_dma_pkg::addr_t mem [port_dma_pkg::FP_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W:0]      used;
    logic                full;
    logic [FILL_W-1:0]   fill_cnt;
    logic                fill_busy;
    port_dma_pkg::addr_t fill_addr;
    logic                push;
    port_dma_pkg::addr_t push_dat;
    logic                pull;

    port_dma_pkg::refill_state_t rf_state;
    logic                        pend_vld;
    port_dma_pkg::cnt_t          pend_cells;
    logic                        take_pend;
    logic                        park;

    ////////////////////
    // power-up fill
    ////////////////////

    // fill runs until exactly FP_INIT_ENTRIES were written
    assign fill_busy = (fill_cnt != FILL_W'(port_dma_pkg::FP_INIT_ENTRIES));
    // port in the top bits, index in the low bits
    assign fill_addr = {P_PORT, {PAD_W{1'b0}}, fill_cnt[IDX_W-1:0]};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fill_cnt <= '0;
        end else if (fill_busy && push) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    ////////////////////
    // address FIFO
    ////////////////////

    // write port belongs to the fill first, then to the MMU
    assign push     = fill_busy ? (i_locked && !full) : (i_fp_wr_en && !full);
    assign push_dat = fill_busy ? fill_addr : i_fp_wr_dat;
    assign pull     = i_pop && !o_empty;

    assign full    = (used == (PTR_W + 1)'(port_dma_pkg::FP_DEPTH));
    assign o_empty = (used == '0);
    // head word always visible
    assign o_addr  = mem[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_dat;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pull) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pull})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1;
                default: used <= used;
            endcase
        end
    end

    ////////////////////
    // refill request
    ////////////////////

    // a start seen while busy waits in a one-entry slot
    assign take_pend = (rf_state == port_dma_pkg::RF_IDLE) && pend_vld;
    assign park      = i_pkt_start && !((rf_state == port_dma_pkg::RF_IDLE) && !pend_vld);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pend_vld <= 1'b0;
        end else if (park) begin
            pend_vld <= 1'b1;
        end else if (take_pend) begin
            pend_vld <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (park) begin
            pend_cells <= i_pkt_cells;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rf_state <= port_dma_pkg::RF_IDLE;
            o_length <= '0;
        end else begin
            case (rf_state)
                port_dma_pkg::RF_IDLE: begin
                    // older parked start goes first
                    if (pend_vld) begin
                        o_length <= pend_cells;
                        rf_state <= port_dma_pkg::RF_ASK;
                    end else if (i_pkt_start) begin
                        o_length <= i_pkt_cells;
                        rf_state <= port_dma_pkg::RF_ASK;
                    end
                end
                port_dma_pkg::RF_ASK: begin
                    rf_state <= port_dma_pkg::RF_HOLD;
                end
                port_dma_pkg::RF_HOLD: begin
                    if (i_mmu_malloc_done) begin
                        rf_state <= port_dma_pkg::RF_IDLE;
                    end
                end
                default: begin
                    rf_state <= port_dma_pkg::RF_IDLE;
                end
            endcase
        end
    end

    // request level from ask through the done cycle
    assign o_aply_req = (rf_state != port_dma_pkg::RF_IDLE);

endmodule

// File: verilog/port_dma_pkg.sv
package port_dma_pkg;

    ////////////////////
    // widths
    ////////////////////

    localparam int DATA_W = 32;
    localparam int ADDR_W = 16;
    localparam int CNT_W  = 7;
    localparam int PORT_W = 4;

    // header layout
    // src_port 21:18, length 17:7, priority 6:4, dest_port 3:0
    localparam int HDR_LEN_LSB = 7;
    localparam int HDR_LEN_MSB = 17;
    // priority plus destination port
    localparam int HDR_ROUTE_W = 7;

    // 16 bytes per cell
    localparam int CELL_BYTES_LOG2 = 4;

    // free list sizing
    localparam int FP_INIT_ENTRIES = 128;
    localparam int FP_DEPTH        = 256;

    // descriptor is first address, cell count, route bits
    localparam int DESC_W = ADDR_W + CNT_W + HDR_ROUTE_W;

    ////////////////////
    // types
    ////////////////////

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [CNT_W-1:0]  cnt_t;
    typedef logic [PORT_W-1:0] port_t;
    typedef logic [DESC_W-1:0] desc_t;

    // packet writer states
    typedef enum logic [2:0] {
        WR_IDLE,
        WR_REQUEST,
        WR_WAIT_READY,
        WR_HEADER,
        WR_BODY,
        WR_DONE
    } writer_state_t;

    // free list refill request states
    typedef enum logic [1:0] {
        RF_IDLE,
        RF_ASK,
        RF_HOLD
    } refill_state_t;

endpackage
